// ==== hdl/arcadePkg.sv ====
package arcadePkg;

	// 12-bit rgb palette with 4 bits per channel
	localparam logic [11:0] ColBlack          = 12'h000;
	localparam logic [11:0] ColRed            = 12'hF00;
	localparam logic [11:0] ColGrey           = 12'hCCC;
	localparam logic [11:0] ColPink           = 12'hF88;
	localparam logic [11:0] ColDarkGrey       = 12'h666;
	localparam logic [11:0] ColMediumGrey     = 12'h999;
	localparam logic [11:0] ColBackground     = 12'h014; // deep space blue
	localparam logic [11:0] ColGreen          = 12'h1F0;
	localparam logic [11:0] ColCream          = 12'hFEB;
	localparam logic [11:0] ColTunnelBlue     = 12'h015;
	localparam logic [11:0] ColDisabledDark   = 12'h111;
	localparam logic [11:0] ColDisabledMedium = 12'h222;

	// first visible pixel of the 640x480 area
	localparam logic [10:0] HOrigin = 11'd144;
	localparam logic [10:0] VOrigin = 11'd35;

	// shapes as left, width, top and height from the origin
	localparam int TunnelVL = 220, TunnelVW = 200, TunnelVT = 0, TunnelVH = 480;
	localparam int TunnelHL = 0, TunnelHW = 640, TunnelHT = 171, TunnelHH = 159;

	localparam int HullMidL = 248, HullMidW = 144, HullMidT = 248, HullMidH = 20;
	localparam int HullTopL = 263, HullTopW = 114, HullTopT = 225, HullTopH = 23;
	localparam int HullBtmL = 263, HullBtmW = 114, HullBtmT = 268, HullBtmH = 20;
	localparam int LegLeftL = 273, LegRightL = 351, LegW = 16, LegT = 288, LegH = 20;

	localparam int ShieldOuterW = 10, ShieldOuterT = 205, ShieldOuterH = 105;
	localparam int ShieldInnerW = 11, ShieldInnerT = 200, ShieldInnerH = 115;
	localparam int ShieldLeftOuterL = 227, ShieldLeftInnerL = 237;
	localparam int ShieldRightOuterL = 402, ShieldRightInnerL = 392;

	// cannon parts share columns but not rows
	localparam int CanTipL = 314, CanTipW = 12, CanTipH = 10;
	localparam int CanBodyL = 309, CanBodyW = 22, CanBodyH = 30;
	localparam int CanBaseL = 314, CanBaseW = 12, CanBaseH = 2;
	localparam int CanStripL = 309, CanStripW = 22, CanStripH = 4;
	localparam int TopTipT = 152, TopBodyT = 162, TopBaseT = 192, TopStripT = 165;
	localparam int BtmTipT = 320, BtmBodyT = 290, BtmBaseT = 288, BtmStripT = 312;

	// monster parts with rows as offsets from the monster top
	localparam int MonL = 290, MonW = 59, MonH = 52;
	localparam int EyeL = 306, EyeW = 28, EyeOff = 13, EyeH = 26;
	localparam int PupilL = 314, PupilW = 12, PupilOff = 27, PupilH = 12;
	localparam int MouthL = 309, MouthW = 22, MouthOff = 41, MouthH = 5;
	localparam int TopMonT = 24, BtmMonT = 406;
	localparam int TopMaskT = 0, BtmMaskT = 458, MaskH = 24; // laser column past the monster

	// laser travel in rows from VOrigin
	localparam logic signed [10:0] LaserStep     = 11'sd4;
	localparam logic signed [10:0] TopLaserStart = 11'sd256;
	localparam logic signed [10:0] TopLaserEnd   = 11'sd0;
	localparam logic signed [10:0] TopHitPos     = 11'sd76;  // underside of top monster
	localparam logic signed [10:0] BtmLaserStart = 11'sd226;
	localparam logic signed [10:0] BtmLaserEnd   = 11'sd478;
	localparam logic signed [10:0] BtmHitPos     = 11'sd406; // top edge of bottom monster
	localparam logic signed [10:0] LaserX        = 11'sd318;
	localparam logic signed [10:0] LaserW        = 11'sd4;
	localparam logic signed [10:0] BurstGap      = 11'sd40;  // bolt to bolt pitch
	localparam logic signed [10:0] BoltLen       = 11'sd24;

	localparam int ApbAddrW = 12;
	localparam int ApbDataW = 32;

	localparam logic [ApbAddrW-1:0] CtrlAddr   = 12'h000;
	localparam logic [ApbAddrW-1:0] StatusAddr = 12'h004;

	localparam int CtrlTopMonster = 0;
	localparam int CtrlBtmMonster = 1;
	localparam int CtrlTopBroken  = 2;
	localparam int CtrlBtmBroken  = 3;

	localparam int StTopAlive    = 0;
	localparam int StBtmAlive    = 1;
	localparam int StTopShooting = 2;
	localparam int StBtmShooting = 3;

	// inclusive on both edges
	function automatic logic pixelInRect(input logic [9:0] h, input logic [9:0] v,
		input int left, input int width, input int top, input int height);
		int x;
		int y;
		x = int'(h) - int'(HOrigin);
		y = int'(v) - int'(VOrigin);
		return (x >= left) && (x <= left + width) && (y >= top) && (y <= top + height);
	endfunction

endpackage

// ==== hdl/arcadeRegs.sv ====
`timescale 1ns/1ns

module arcadeRegs import arcadePkg::*; (
	input  logic Clk,
	input  logic Reset,
	input  logic pSel,
	input  logic pEnable,
	input  logic pWrite,
	input  logic [ApbAddrW-1:0] pAddr,
	input  logic [ApbDataW-1:0] pWData,
	output logic [ApbDataW-1:0] pRData,
	output logic pReady,
	output logic pSlvErr,
	gameStateIf.regs state
);
	logic access;
	logic ctrlSel;
	logic statusSel;
	logic [3:0] ctrl;
	logic topAlive;
	logic btmAlive;
	logic [ApbDataW-1:0] statusWord;

	assign access    = pSel && pEnable; // access phase
	assign ctrlSel   = (pAddr == CtrlAddr);
	assign statusSel = (pAddr == StatusAddr);

	assign pReady  = access; // zero wait states
	assign pSlvErr = access && !ctrlSel && !statusSel;

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			ctrl     <= 4'b0000;
			topAlive <= 1'b0;
			btmAlive <= 1'b0;
		end else begin
			if (access && pWrite && ctrlSel) begin
				ctrl     <= pWData[3:0];
				topAlive <= pWData[CtrlTopMonster];
				btmAlive <= pWData[CtrlBtmMonster];
			end
			// a hit on the same edge as a write wins
			if (state.topHit) begin
				topAlive             <= 1'b0;
				ctrl[CtrlTopMonster] <= 1'b0; // enable reads back cleared
			end
			if (state.btmHit) begin
				btmAlive             <= 1'b0;
				ctrl[CtrlBtmMonster] <= 1'b0;
			end
		end
	end

	assign state.topAlive  = topAlive;
	assign state.btmAlive  = btmAlive;
	assign state.topBroken = ctrl[CtrlTopBroken];
	assign state.btmBroken = ctrl[CtrlBtmBroken];

	always_comb begin
		statusWord                = '0;
		statusWord[StTopAlive]    = topAlive;
		statusWord[StBtmAlive]    = btmAlive;
		statusWord[StTopShooting] = state.topShooting;
		statusWord[StBtmShooting] = state.btmShooting;
	end

	// read data only in a read access phase
	always_comb begin
		pRData = '0;
		if (access && !pWrite) begin
			if (ctrlSel) begin
				pRData = {{(ApbDataW-4){1'b0}}, ctrl};
			end else if (statusSel) begin
				pRData = statusWord;
			end
		end
	end

endmodule

// ==== hdl/arcadeTop.sv ====
`timescale 1ns/1ns

module arcadeTop import arcadePkg::*; (
	input  logic Clk,
	input  logic Reset,
	input  logic pSel,
	input  logic pEnable,
	input  logic pWrite,
	input  logic [ApbAddrW-1:0] pAddr,
	input  logic [ApbDataW-1:0] pWData,
	output logic [ApbDataW-1:0] pRData,
	output logic pReady,
	output logic pSlvErr,
	input  logic [9:0] hCount,
	input  logic [9:0] vCount,
	input  logic bright,
	input  logic up,
	input  logic down,
	output logic [11:0] rgb
);
	logic frameTick; // pixel (0,0), paces the lasers

	gameStateIf gameState();

	arcadeRegs u_regs (
		.Clk     (Clk),
		.Reset   (Reset),
		.pSel    (pSel),
		.pEnable (pEnable),
		.pWrite  (pWrite),
		.pAddr   (pAddr),
		.pWData  (pWData),
		.pRData  (pRData),
		.pReady  (pReady),
		.pSlvErr (pSlvErr),
		.state   (gameState.regs)
	);

	laserCannon #(.Upward(1'b1)) u_topCannon (
		.Clk       (Clk),
		.Reset     (Reset),
		.fire      (up),
		.frameTick (frameTick),
		.cannon    (gameState.topCannon)
	);

	laserCannon #(.Upward(1'b0)) u_btmCannon (
		.Clk       (Clk),
		.Reset     (Reset),
		.fire      (down),
		.frameTick (frameTick),
		.cannon    (gameState.btmCannon)
	);

	spriteRenderer u_renderer (
		.Clk       (Clk),
		.Reset     (Reset),
		.hCount    (hCount),
		.vCount    (vCount),
		.bright    (bright),
		.state     (gameState.render),
		.rgb       (rgb),
		.frameTick (frameTick)
	);

endmodule

// ==== hdl/gameStateIf.sv ====
`timescale 1ns/1ns

interface gameStateIf;
	logic topAlive;
	logic btmAlive;
	logic topBroken;
	logic btmBroken;
	logic signed [10:0] topLaser; // row of the leading bolt
	logic signed [10:0] btmLaser;
	logic topShooting;
	logic btmShooting;
	logic topHit; // single cycle, on a frame tick
	logic btmHit;

	modport regs (output topAlive, btmAlive, topBroken, btmBroken,
		input topHit, btmHit, topShooting, btmShooting);

	modport topCannon (input topAlive, topBroken, output topLaser, topShooting, topHit);

	modport btmCannon (input btmAlive, btmBroken, output btmLaser, btmShooting, btmHit);

	modport render (input topAlive, btmAlive, topBroken, btmBroken,
		topLaser, btmLaser, topShooting, btmShooting);
endinterface

// ==== hdl/laserCannon.sv ====
`timescale 1ns/1ns

module laserCannon import arcadePkg::*; #(
	parameter bit Upward = 1'b1
) (
	input logic Clk,
	input logic Reset,
	input logic fire,
	input logic frameTick,
	gameStateIf cannon
);
	logic alive;
	logic broken;
	logic shooting;
	logic hit;
	logic atEnd;
	logic signed [10:0] laser;
	logic signed [10:0] startPos;
	logic signed [10:0] endPos;
	logic signed [10:0] hitPos;
	logic signed [10:0] step;

	assign startPos = Upward ? TopLaserStart : BtmLaserStart;
	assign endPos   = Upward ? TopLaserEnd : BtmLaserEnd;
	assign hitPos   = Upward ? TopHitPos : BtmHitPos;
	assign step     = Upward ? -LaserStep : LaserStep; // top shots travel up the screen

	// both tests only count on a frame tick
	assign hit   = shooting && frameTick && alive && (laser == hitPos);
	assign atEnd = shooting && frameTick && (laser == endPos);

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			shooting <= 1'b0;
			laser    <= startPos;
		end else if (hit || atEnd) begin
			shooting <= 1'b0;
			laser    <= startPos; // rearm
		end else if (shooting) begin
			if (frameTick) begin
				laser <= laser + step;
			end
		end else if (fire && !broken) begin
			shooting <= 1'b1;
		end
	end

	// hook up to the matching half of the game state
	if (Upward) begin : gTop
		assign alive               = cannon.topAlive;
		assign broken              = cannon.topBroken;
		assign cannon.topLaser     = laser;
		assign cannon.topShooting  = shooting;
		assign cannon.topHit       = hit;
	end else begin : gBtm
		assign alive               = cannon.btmAlive;
		assign broken              = cannon.btmBroken;
		assign cannon.btmLaser     = laser;
		assign cannon.btmShooting  = shooting;
		assign cannon.btmHit       = hit;
	end

endmodule

// ==== hdl/spriteRenderer.sv ====
`timescale 1ns/1ns

module spriteRenderer import arcadePkg::*; (
	input  logic Clk,
	input  logic Reset,
	input  logic [9:0] hCount,
	input  logic [9:0] vCount,
	input  logic bright,
	gameStateIf.render state,
	output logic [11:0] rgb,
	output logic frameTick
);
	logic tunnel;
	logic shield;
	logic hull;
	logic topDark;
	logic topMedium;
	logic btmDark;
	logic btmMedium;
	logic topMonster;
	logic btmMonster;
	logic topBolts;
	logic btmBolts;
	logic [11:0] topMonColour;
	logic [11:0] btmMonColour;
	logic [11:0] pixelColour;

	function automatic logic cannonDark(input logic [9:0] h, input logic [9:0] v,
		input int tipTop, input int bodyTop);
		return pixelInRect(h, v, CanTipL, CanTipW, tipTop, CanTipH)
			|| pixelInRect(h, v, CanBodyL, CanBodyW, bodyTop, CanBodyH);
	endfunction

	function automatic logic cannonMedium(input logic [9:0] h, input logic [9:0] v,
		input int baseTop, input int stripTop);
		return pixelInRect(h, v, CanBaseL, CanBaseW, baseTop, CanBaseH)
			|| pixelInRect(h, v, CanStripL, CanStripW, stripTop, CanStripH);
	endfunction

	// body holds eye, pupil and mouth
	function automatic logic monsterArea(input logic [9:0] h, input logic [9:0] v,
		input int monTop, input int maskTop);
		return pixelInRect(h, v, MonL, MonW, monTop, MonH)
			|| pixelInRect(h, v, int'(LaserX), int'(LaserW), maskTop, MaskH);
	endfunction

	function automatic logic [11:0] monsterColour(input logic [9:0] h, input logic [9:0] v,
		input int monTop);
		if (pixelInRect(h, v, PupilL, PupilW, monTop + PupilOff, PupilH)
			|| pixelInRect(h, v, MouthL, MouthW, monTop + MouthOff, MouthH)) begin
			return ColBlack;
		end else if (pixelInRect(h, v, EyeL, EyeW, monTop + EyeOff, EyeH)) begin
			return ColCream;
		end else if (pixelInRect(h, v, MonL, MonW, monTop, MonH)) begin
			return ColRed;
		end
		return ColTunnelBlue; // mask hides the bolts behind the monster
	endfunction

	// three bolts, firstTop is the upper row of the highest one
	function automatic logic burst(input logic [9:0] h, input logic [9:0] v, input int firstTop);
		logic inBolt;
		inBolt = 1'b0;
		for (int k = 0; k < 3; k++) begin
			inBolt |= pixelInRect(h, v, int'(LaserX), int'(LaserW),
				firstTop + k * int'(BurstGap), int'(BoltLen));
		end
		return inBolt;
	endfunction

	assign frameTick = (hCount == 10'd0) && (vCount == 10'd0);

	assign tunnel = pixelInRect(hCount, vCount, TunnelVL, TunnelVW, TunnelVT, TunnelVH)
		|| pixelInRect(hCount, vCount, TunnelHL, TunnelHW, TunnelHT, TunnelHH);

	assign shield =
		pixelInRect(hCount, vCount, ShieldLeftOuterL, ShieldOuterW, ShieldOuterT, ShieldOuterH)
		|| pixelInRect(hCount, vCount, ShieldLeftInnerL, ShieldInnerW, ShieldInnerT, ShieldInnerH)
		|| pixelInRect(hCount, vCount, ShieldRightOuterL, ShieldOuterW, ShieldOuterT, ShieldOuterH)
		|| pixelInRect(hCount, vCount, ShieldRightInnerL, ShieldInnerW, ShieldInnerT, ShieldInnerH);

	assign hull = pixelInRect(hCount, vCount, HullMidL, HullMidW, HullMidT, HullMidH)
		|| pixelInRect(hCount, vCount, HullTopL, HullTopW, HullTopT, HullTopH)
		|| pixelInRect(hCount, vCount, HullBtmL, HullBtmW, HullBtmT, HullBtmH)
		|| pixelInRect(hCount, vCount, LegLeftL, LegW, LegT, LegH)
		|| pixelInRect(hCount, vCount, LegRightL, LegW, LegT, LegH);

	assign topDark   = cannonDark(hCount, vCount, TopTipT, TopBodyT);
	assign topMedium = cannonMedium(hCount, vCount, TopBaseT, TopStripT);
	assign btmDark   = cannonDark(hCount, vCount, BtmTipT, BtmBodyT);
	assign btmMedium = cannonMedium(hCount, vCount, BtmBaseT, BtmStripT);

	assign topMonster   = state.topAlive && monsterArea(hCount, vCount, TopMonT, TopMaskT);
	assign btmMonster   = state.btmAlive && monsterArea(hCount, vCount, BtmMonT, BtmMaskT);
	assign topMonColour = monsterColour(hCount, vCount, TopMonT);
	assign btmMonColour = monsterColour(hCount, vCount, BtmMonT);

	// top burst trails below the leading bolt, bottom burst trails above
	assign topBolts = state.topShooting && burst(hCount, vCount,
		int'(state.topLaser) - int'(BoltLen) - 2 * int'(BurstGap));
	assign btmBolts = state.btmShooting && burst(hCount, vCount, int'(state.btmLaser));

	always_comb begin
		if (!bright) begin
			pixelColour = ColBlack;
		end else if (state.topBroken && (topMedium || topDark)) begin
			pixelColour = topMedium ? ColDisabledMedium : ColDisabledDark;
		end else if (state.btmBroken && (btmMedium || btmDark)) begin
			pixelColour = btmMedium ? ColDisabledMedium : ColDisabledDark;
		end else if (shield) begin
			pixelColour = ColPink;
		end else if (hull) begin
			pixelColour = ColGrey;
		end else if (topMedium || btmMedium) begin
			pixelColour = ColMediumGrey; // strip sits on the cannon body
		end else if (topDark || btmDark) begin
			pixelColour = ColDarkGrey;
		end else if (topMonster) begin
			pixelColour = topMonColour;
		end else if (btmMonster) begin
			pixelColour = btmMonColour;
		end else if (topBolts || btmBolts) begin
			pixelColour = ColGreen;
		end else if (tunnel) begin
			pixelColour = ColTunnelBlue;
		end else begin
			pixelColour = ColBackground;
		end
	end

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			rgb <= 12'h000;
		end else begin
			rgb <= pixelColour; // one cycle behind the counters
		end
	end

endmodule

// ==== run.sh ====
#!/bin/bash
# build the arcade testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

rm -f sim.log &&
verilator --binary --timing --assert --top-module arcadeTb -f vlog.f -o arcadeSim &&
./obj_dir/arcadeSim +verilator+error+limit+1000 | tee sim.log

grep -qx "Test passed" sim.log && echo "simulation ok" || { echo "simulation FAILED"; exit 1; }

// ==== verification/arcadeTb.sv ====
`timescale 1ns/1ns

module arcadeTb import arcadePkg::*; ();
	localparam int CycleLimit = 20000; // ~200 frame ticks plus probes, with margin

	logic Clk;
	logic Reset;
	logic pSel;
	logic pEnable;
	logic pWrite;
	logic [ApbAddrW-1:0] pAddr;
	logic [ApbDataW-1:0] pWData;
	logic [ApbDataW-1:0] pRData;
	logic pReady;
	logic pSlvErr;
	logic [9:0] hCount;
	logic [9:0] vCount;
	logic bright;
	logic up;
	logic down;
	logic [11:0] rgb;
	logic [ApbDataW-1:0] rdData;
	logic rdErr;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	tbClock u_clock (.Clk(Clk), .Reset(Reset));

	arcadeTop u_arcadeTop (.Clk(Clk), .Reset(Reset), .pSel(pSel), .pEnable(pEnable),
		.pWrite(pWrite), .pAddr(pAddr), .pWData(pWData), .pRData(pRData), .pReady(pReady),
		.pSlvErr(pSlvErr), .hCount(hCount), .vCount(vCount), .bright(bright), .up(up),
		.down(down), .rgb(rgb));

	always @(posedge Clk) begin
		cycles <= cycles + 1;
		if (cycles == CycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", CycleLimit);
			$display("Test failed");
			$finish;
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	// setup phase then access phase, waits for pReady
	task automatic apbAccess(input logic write, input logic [ApbAddrW-1:0] addr,
		input logic [ApbDataW-1:0] data);
		@(posedge Clk);
		pSel <= 1'b1;
		pEnable <= 1'b0;
		pWrite <= write;
		pAddr <= addr;
		pWData <= data;
		@(posedge Clk);
		pEnable <= 1'b1;
		@(negedge Clk);
		while (!pReady) @(negedge Clk);
		rdData = pRData;
		rdErr = pSlvErr;
		@(posedge Clk); // write lands here
		pSel <= 1'b0;
		pEnable <= 1'b0;
	endtask

	task automatic readCheck(input string name, input logic [ApbAddrW-1:0] addr,
		input logic [ApbDataW-1:0] exp);
		apbAccess(1'b0, addr, '0);
		checkValue(name, rdData, exp);
	endtask

	// x and y are relative to the visible origin
	task automatic probe(input int x, input int y, input logic vis, input logic [11:0] exp);
		@(posedge Clk);
		hCount <= 10'(int'(HOrigin) + x);
		vCount <= 10'(int'(VOrigin) + y);
		bright <= vis;
		@(posedge Clk); // rgb registered on this edge
		@(negedge Clk);
		checkValue("rgb", {20'h0, rgb}, {20'h0, exp});
	endtask

	task automatic frameTicks(input int count);
		repeat (count) begin
			@(posedge Clk);
			hCount <= 10'd0;
			vCount <= 10'd0;
			@(posedge Clk); // tick edge
			hCount <= 10'd1;
		end
	endtask

	task automatic pulseFire(input logic top);
		@(posedge Clk);
		up <= top;
		down <= !top;
		@(posedge Clk);
		up <= 1'b0;
		down <= 1'b0;
	endtask

	initial begin
		int x;
		int y;
		int n;
		void'($urandom(32'h645132ba));
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWData = '0;
		hCount = 10'd1; // keep off (0,0) until a tick is wanted
		vCount = 10'd0;
		bright = 1'b0;
		up = 1'b0;
		down = 1'b0;
		@(negedge Clk);
		checkValue("rgb", {20'h0, rgb}, 32'h0);
		while (Reset) @(posedge Clk);

		readCheck("status", StatusAddr, 32'h0);
		readCheck("ctrl", CtrlAddr, 32'h0);

		probe(100, 100, 1'b0, ColBlack);
		repeat (8) begin
			if ($urandom_range(1, 0) == 1) begin
				x = int'($urandom_range(420, 220)); // vertical tunnel above the ship
				y = int'($urandom_range(140, 0));
			end else begin
				x = int'($urandom_range(200, 0)); // horizontal tunnel, left arm
				y = int'($urandom_range(330, 171));
			end
			probe(x, y, 1'b1, ColTunnelBlue);
			if ($urandom_range(1, 0) == 1) begin
				x = int'($urandom_range(200, 0));
				y = int'($urandom_range(160, 0));
			end else begin
				x = int'($urandom_range(639, 440));
				y = int'($urandom_range(479, 340));
			end
			probe(x, y, 1'b1, ColBackground);
		end
		probe(230, 250, 1'b1, ColPink); // left shield
		probe(300, 258, 1'b1, ColGrey);
		probe(310, 180, 1'b1, ColDarkGrey); // top cannon body

		apbAccess(1'b1, CtrlAddr, 32'd1 << CtrlTopMonster);
		probe(292, 30, 1'b1, ColRed);
		probe(308, 40, 1'b1, ColCream);
		apbAccess(1'b1, CtrlAddr, 32'h0);
		probe(292, 30, 1'b1, ColTunnelBlue);

		// top shot into a live monster
		apbAccess(1'b1, CtrlAddr, 32'd1 << CtrlTopMonster);
		pulseFire(1'b1);
		readCheck("status", StatusAddr, (32'd1 << StTopAlive) | (32'd1 << StTopShooting));
		frameTicks(10);
		y = int'(TopLaserStart) - 10 * int'(LaserStep) - int'(BoltLen) - 2 * int'(BurstGap);
		probe(int'(LaserX) + 2, y + 8, 1'b1, ColGreen); // inside the highest bolt
		probe(int'(LaserX) + 2, y + int'(BoltLen) + 4, 1'b1, ColTunnelBlue);
		n = (int'(TopLaserStart) - int'(TopHitPos)) / int'(LaserStep);
		frameTicks(n - 10);
		readCheck("status", StatusAddr, (32'd1 << StTopAlive) | (32'd1 << StTopShooting));
		frameTicks(1); // laser sits on the hit row
		readCheck("status", StatusAddr, 32'h0);
		readCheck("ctrl", CtrlAddr, 32'h0);

		// bottom shot, nothing to hit
		pulseFire(1'b0);
		n = (int'(BtmLaserEnd) - int'(BtmLaserStart)) / int'(LaserStep);
		frameTicks(n);
		readCheck("status", StatusAddr, 32'd1 << StBtmShooting);
		frameTicks(1);
		readCheck("status", StatusAddr, 32'h0);

		apbAccess(1'b1, CtrlAddr, 32'd1 << CtrlTopBroken);
		pulseFire(1'b1);
		readCheck("status", StatusAddr, 32'h0);
		readCheck("ctrl", CtrlAddr, 32'd1 << CtrlTopBroken);
		probe(310, 180, 1'b1, ColDisabledDark);
		apbAccess(1'b1, 12'h008, 32'h0);
		checkValue("pSlvErr", {31'h0, rdErr}, 32'h1);

		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			u_arcadeTop.u_assert.failCount);
		if (errors == 0 && u_arcadeTop.u_assert.failCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end
endmodule

// ==== verification/arcadeTb_assert.sv ====
`timescale 1ns/1ns

module arcadeAssert import arcadePkg::*; (
	input logic Clk,
	input logic Reset,
	input logic bright,
	input logic [11:0] rgb,
	input logic pSel,
	input logic pEnable,
	input logic [ApbAddrW-1:0] pAddr,
	input logic pReady,
	input logic pSlvErr
);
	int failCount = 0;

	blankIsBlack: assert property (@(posedge Clk) disable iff (Reset)
		!bright |=> (rgb == ColBlack))
		else begin
			$error("rgb is not black one cycle after bright went low");
			failCount++;
		end

	readyInAccess: assert property (@(posedge Clk) disable iff (Reset)
		(pSel && pEnable) |-> pReady)
		else begin
			$error("pReady low in an access phase");
			failCount++;
		end

	noErrOnKnownAddr: assert property (@(posedge Clk) disable iff (Reset)
		(pSel && (pAddr == CtrlAddr || pAddr == StatusAddr)) |-> !pSlvErr)
		else begin
			$error("pSlvErr raised for a mapped register address");
			failCount++;
		end

	// rgb already cleared from the second reset edge on
	rgbClearInReset: assert property (@(posedge Clk)
		(Reset && $past(Reset)) |-> (rgb == ColBlack))
		else begin
			$error("rgb not zero while Reset is high");
			failCount++;
		end
endmodule

bind arcadeTop arcadeAssert u_assert (
	.Clk     (Clk),
	.Reset   (Reset),
	.bright  (bright),
	.rgb     (rgb),
	.pSel    (pSel),
	.pEnable (pEnable),
	.pAddr   (pAddr),
	.pReady  (pReady),
	.pSlvErr (pSlvErr)
);

// ==== verification/tbClock.sv ====
`timescale 1ns/1ns

module tbClock (
	output logic Clk,
	output logic Reset
);
	localparam int HalfPeriod = 4; // 8 ns period

	initial begin
		Clk = 1'b0;
		forever #HalfPeriod Clk = ~Clk;
	end

	initial begin
		Reset = 1'b1;
		repeat (3) @(posedge Clk); // three cycles in reset
		Reset <= 1'b0;
	end
endmodule

// ==== vlog.f ====
hdl/arcadePkg.sv
hdl/gameStateIf.sv
hdl/arcadeRegs.sv
hdl/laserCannon.sv
hdl/spriteRenderer.sv
hdl/arcadeTop.sv
verification/tbClock.sv
verification/arcadeTb_assert.sv
verification/arcadeTb.sv
